/* hdl/cpu_pkg.sv */
// Shared types for the five-stage core
// Word and register index types, opcode and ALU operation encodings
// Instruction views, pipeline register structs, forwarding selects
// Source register selection used by decode and execute
package cpu_pkg;

   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;

   typedef enum logic [4:0] {
      OP_RTYPE = 5'b00000,
      OP_J     = 5'b00001,
      OP_BNE   = 5'b00010,
      OP_ADDI  = 5'b00101,
      OP_BLT   = 5'b00110,
      OP_SW    = 5'b00111,
      OP_LW    = 5'b01000
   } opcode_e;

   typedef enum logic [4:0] {
      ALU_ADD = 5'b00000,
      ALU_SUB = 5'b00001,
      ALU_AND = 5'b00010,
      ALU_OR  = 5'b00011,
      ALU_SLL = 5'b00100,
      ALU_SRA = 5'b00101
   } alu_op_e;

   typedef struct packed {
      opcode_e  opcode;
      reg_idx_t rd;
      reg_idx_t rs;
      reg_idx_t rt;
      logic [4:0] shamt;
      alu_op_e  alu_op;
      logic [1:0] zero;
   } r_fmt_t;

   typedef struct packed {
      opcode_e  opcode;
      reg_idx_t rd;
      reg_idx_t rs;
      logic signed [16:0] imm;
   } i_fmt_t;

   // Same word, two decodings; j target is i[26:0]
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
   } instr_u;

   typedef struct packed {
      word_t  pc1;
      instr_u instr;
   } fd_reg_t;

   typedef struct packed {
      word_t    pc1;
      instr_u   instr;
      word_t    a;
      word_t    b;
      reg_idx_t rd;
      logic     we;
      logic     load;
   } dx_reg_t;

   typedef struct packed {
      word_t    alu;
      word_t    sdata;
      reg_idx_t rd;
      logic     we;
      logic     load;
      logic     store;
   } xm_reg_t;

   typedef struct packed {
      word_t    alu;
      word_t    ldata;
      reg_idx_t rd;
      logic     we;
      logic     load;
   } mw_reg_t;

   typedef enum logic [1:0] {
      FWD_REG = 2'b00,
      FWD_MEM = 2'b01,
      FWD_WB  = 2'b10
   } fwd_sel_e;

   // Operand A source; branches compare rd against rs
   function automatic reg_idx_t src_a(instr_u ins);
      case (ins.r.opcode)
         OP_RTYPE, OP_ADDI, OP_LW, OP_SW: src_a = ins.r.rs;
         OP_BNE, OP_BLT:                  src_a = ins.r.rd;
         default:                         src_a = '0;
      endcase
   endfunction

   // Operand B source; sw stores rd
   function automatic reg_idx_t src_b(instr_u ins);
      case (ins.r.opcode)
         OP_RTYPE:       src_b = ins.r.rt;
         OP_BNE, OP_BLT: src_b = ins.r.rs;
         OP_SW:          src_b = ins.r.rd;
         default:        src_b = '0;
      endcase
   endfunction

endpackage

/* hdl/fetch_stage.sv */
// Fetch stage
// Program counter with redirect and stall
// Fetch/decode pipeline register
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; #(
   parameter word_t RESET_PC = '0
) (
   input  logic    clk,
   input  logic    clr,
   input  logic    stall,
   input  logic    flush,
   input  logic    redirect,
   input  word_t   redirect_pc,
   input  word_t   imem_data,
   output word_t   imem_addr,
   output fd_reg_t fd
);

   word_t pc;
   word_t pc_plus1;

   assign pc_plus1  = pc + 32'd1;
   assign imem_addr = pc;

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         pc <= RESET_PC;
      end else if (redirect) begin
         pc <= redirect_pc;  // Taken branch or j from execute
      end else if (!stall) begin
         pc <= pc_plus1;
      end
   end

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         fd <= '0;
      end else if (flush) begin
         fd <= '0;  // Bubble, decodes as add r0
      end else if (!stall) begin
         fd.pc1   <= pc_plus1;
         fd.instr <= instr_u'(imem_data);
      end
   end

endmodule

/* hdl/reg_file.sv */
// Register file
// 32 x 32 bit, two read ports, one write port
// Write data bypassed to same-cycle reads
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
   input  logic     clk,
   input  logic     clr,
   input  logic     we,
   input  reg_idx_t waddr,
   input  reg_idx_t raddr_a,
   input  reg_idx_t raddr_b,
   input  word_t    wdata,
   output word_t    rdata_a,
   output word_t    rdata_b
);

   word_t regs [32];

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         for (int i = 0; i < 32; i++) regs[i] <= '0;
      end else if (we && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   // r0 is hardwired to zero
   assign rdata_a = (raddr_a == '0) ? '0 :
                    (we && waddr == raddr_a) ? wdata : regs[raddr_a];
   assign rdata_b = (raddr_b == '0) ? '0 :
                    (we && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

/* hdl/decode_stage.sv */
// Decode stage
// Register read addressing and control flags
// Decode/execute pipeline register
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
   input  logic     clk,
   input  logic     clr,
   input  logic     stall,
   input  logic     flush,
   input  fd_reg_t  fd,
   input  word_t    rdata_a,
   input  word_t    rdata_b,
   output reg_idx_t raddr_a,
   output reg_idx_t raddr_b,
   output dx_reg_t  dx
);

   logic wr_en;
   logic is_load;

   // Unused ports read r0 so they never trigger a stall
   assign raddr_a = src_a(fd.instr);
   assign raddr_b = src_b(fd.instr);

   always_comb begin
      wr_en   = 1'b0;
      is_load = 1'b0;
      case (fd.instr.r.opcode)
         OP_RTYPE, OP_ADDI: wr_en = 1'b1;
         OP_LW: begin
            wr_en   = 1'b1;
            is_load = 1'b1;
         end
         default: ;  // j, branches, sw write nothing
      endcase
   end

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         dx <= '0;
      end else if (flush || stall) begin
         dx <= '0;  // Bubble into execute
      end else begin
         dx.pc1   <= fd.pc1;
         dx.instr <= fd.instr;
         dx.a     <= rdata_a;
         dx.b     <= rdata_b;
         dx.rd    <= fd.instr.r.rd;
         dx.we    <= wr_en;
         dx.load  <= is_load;
      end
   end

endmodule

/* hdl/hazard_unit.sv */
// Hazard unit
// Operand forwarding selects for execute
// Load-use stall detection
`timescale 1ns/1ps

module hazard_unit import cpu_pkg::*; (
   input  reg_idx_t rs_a,
   input  reg_idx_t rs_b,
   input  xm_reg_t  xm,
   input  mw_reg_t  mw,
   input  reg_idx_t dec_a,
   input  reg_idx_t dec_b,
   input  logic     dx_load,
   input  reg_idx_t dx_rd,
   output fwd_sel_e fwd_a,
   output fwd_sel_e fwd_b,
   output logic     stall
);

   // Memory stage is younger, so it wins over writeback
   function automatic fwd_sel_e pick(reg_idx_t src, xm_reg_t x, mw_reg_t w);
      if (src == '0)
         pick = FWD_REG;
      else if (x.we && x.rd == src)
         pick = FWD_MEM;
      else if (w.we && w.rd == src)
         pick = FWD_WB;
      else
         pick = FWD_REG;
   endfunction

   assign fwd_a = pick(rs_a, xm, mw);
   assign fwd_b = pick(rs_b, xm, mw);

   assign stall = dx_load && dx_rd != '0 && (dx_rd == dec_a || dx_rd == dec_b);

endmodule

/* hdl/execute_stage.sv */
// Execute stage
// Forwarding muxes, immediate extension and ALU
// Branch and jump resolution with redirect
// Execute/memory pipeline register
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
   input  logic     clk,
   input  logic     clr,
   input  dx_reg_t  dx,
   input  fwd_sel_e fwd_a,
   input  fwd_sel_e fwd_b,
   input  word_t    wb_data,
   output xm_reg_t  xm,
   output logic     redirect,
   output logic     flush,
   output word_t    redirect_pc,
   output reg_idx_t rs_a,
   output reg_idx_t rs_b
);

   opcode_e opcode;
   alu_op_e op;
   word_t   opa;
   word_t   opb;
   word_t   imm;
   word_t   jtarget;
   word_t   alu_b;
   word_t   result;
   logic    use_imm;
   logic    taken;

   function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf, word_t mem, word_t wb);
      case (sel)
         FWD_MEM: fwd_mux = mem;
         FWD_WB:  fwd_mux = wb;
         default: fwd_mux = rf;
      endcase
   endfunction

   assign opcode = dx.instr.r.opcode;
   assign rs_a   = src_a(dx.instr);
   assign rs_b   = src_b(dx.instr);

   assign opa = fwd_mux(fwd_a, dx.a, xm.alu, wb_data);
   assign opb = fwd_mux(fwd_b, dx.b, xm.alu, wb_data);

   assign imm     = {{15{dx.instr.i.imm[16]}}, dx.instr.i.imm};
   assign jtarget = {{5{dx.instr.i[26]}}, dx.instr.i[26:0]};
   assign use_imm = opcode == OP_ADDI || opcode == OP_LW || opcode == OP_SW;
   assign alu_b   = use_imm ? imm : opb;
   assign op      = (opcode == OP_RTYPE) ? dx.instr.r.alu_op : ALU_ADD;

   always_comb begin
      case (op)
         ALU_ADD: result = opa + alu_b;
         ALU_SUB: result = opa - alu_b;
         ALU_AND: result = opa & alu_b;
         ALU_OR:  result = opa | alu_b;
         ALU_SLL: result = opa << dx.instr.r.shamt;
         ALU_SRA: result = word_t'($signed(opa) >>> dx.instr.r.shamt);
         default: result = '0;
      endcase
   end

   // Branches compare rd (A) against rs (B)
   always_comb begin
      case (opcode)
         OP_BNE:  taken = opa != opb;
         OP_BLT:  taken = $signed(opa) < $signed(opb);
         OP_J:    taken = 1'b1;
         default: taken = 1'b0;
      endcase
   end

   assign redirect    = taken;
   assign flush       = taken;  // Kills fetch/decode and decode/execute
   assign redirect_pc = (opcode == OP_J) ? jtarget : dx.pc1 + imm;

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         xm <= '0;
      end else begin
         xm.alu   <= result;
         xm.sdata <= opb;  // Forwarded store data
         xm.rd    <= dx.rd;
         xm.we    <= dx.we;
         xm.load  <= dx.load;
         xm.store <= opcode == OP_SW;
      end
   end

endmodule

/* hdl/mem_wb_stage.sv */
// Memory and writeback stages
// Data memory drive and memory/writeback register
// Writeback result select
`timescale 1ns/1ps

module mem_wb_stage import cpu_pkg::*; (
   input  logic     clk,
   input  logic     clr,
   input  xm_reg_t  xm,
   input  word_t    dmem_rdata,
   output word_t    dmem_addr,
   output word_t    dmem_wdata,
   output logic     dmem_wren,
   output mw_reg_t  mw,
   output logic     wb_we,
   output reg_idx_t wb_addr,
   output word_t    wb_data
);

   assign dmem_addr  = xm.alu;
   assign dmem_wdata = xm.sdata;
   assign dmem_wren  = xm.store;

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         mw <= '0;
      end else begin
         mw.alu   <= xm.alu;
         mw.ldata <= dmem_rdata;  // Combinational memory read
         mw.rd    <= xm.rd;
         mw.we    <= xm.we;
         mw.load  <= xm.load;
      end
   end

   assign wb_we   = mw.we;
   assign wb_addr = mw.rd;
   assign wb_data = mw.load ? mw.ldata : mw.alu;

endmodule

/* hdl/cpu_core.sv */
// Five-stage pipelined core, top level
// Stage instances, register file and hazard unit
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
   parameter word_t RESET_PC = '0
) (
   input  logic  clk,
   input  logic  clr,
   output word_t imem_addr,
   input  word_t imem_data,
   output word_t dmem_addr,
   output word_t dmem_wdata,
   output logic  dmem_wren,
   input  word_t dmem_rdata
);

   fd_reg_t  fd;
   dx_reg_t  dx;
   xm_reg_t  xm;
   mw_reg_t  mw;
   reg_idx_t raddr_a, raddr_b;
   word_t    rdata_a, rdata_b;
   reg_idx_t rs_a, rs_b;
   fwd_sel_e fwd_a, fwd_b;
   logic     stall, flush, redirect;
   word_t    redirect_pc;
   logic     wb_we;
   reg_idx_t wb_addr;
   word_t    wb_data;

   fetch_stage #(.RESET_PC(RESET_PC)) u_fetch (
      .clk, .clr, .stall, .flush, .redirect, .redirect_pc,
      .imem_data, .imem_addr, .fd
   );

   decode_stage u_decode (
      .clk, .clr, .stall, .flush, .fd, .rdata_a, .rdata_b,
      .raddr_a, .raddr_b, .dx
   );

   reg_file u_regs (
      .clk, .clr, .we(wb_we), .waddr(wb_addr), .raddr_a, .raddr_b,
      .wdata(wb_data), .rdata_a, .rdata_b
   );

   hazard_unit u_hazard (
      .rs_a, .rs_b, .xm, .mw, .dec_a(raddr_a), .dec_b(raddr_b),
      .dx_load(dx.load), .dx_rd(dx.rd), .fwd_a, .fwd_b, .stall
   );

   execute_stage u_execute (
      .clk, .clr, .dx, .fwd_a, .fwd_b, .wb_data, .xm,
      .redirect, .flush, .redirect_pc, .rs_a, .rs_b
   );

   mem_wb_stage u_mem_wb (
      .clk, .clr, .xm, .dmem_rdata, .dmem_addr, .dmem_wdata, .dmem_wren,
      .mw, .wb_we, .wb_addr, .wb_data
   );

endmodule

/* tb/cpu_core_assert.sv */
// Concurrent assertions on the core's top-level ports
// Reset state, load-use fetch hold, store address range
`timescale 1ns/1ps

module cpu_core_assert import cpu_pkg::*; #(
   parameter word_t RESET_PC   = '0,
   parameter int    DATA_WORDS = 64
) (
   input logic  clk,
   input logic  clr,
   input word_t imem_addr,
   input word_t imem_data,
   input word_t dmem_addr,
   input logic  dmem_wren
);

   int       fails = 0;
   logic     lw_vld, dep_d1, dep_d2, dep_now;
   logic [4:0] lw_rd, op, f_rd, f_rs, f_rt;
   word_t    addr_d1;

   assign {op, f_rd, f_rs, f_rt} = imem_data[31:12];

   // Fetched word reads the previous fetch's load target
   always_comb begin
      case (op)
         5'b00000:           dep_now = f_rs == lw_rd || f_rt == lw_rd;
         5'b00101, 5'b01000: dep_now = f_rs == lw_rd;
         5'b00111, 5'b00010, 5'b00110: dep_now = f_rs == lw_rd || f_rd == lw_rd;
         default:            dep_now = 1'b0;
      endcase
      dep_now = dep_now && lw_vld && lw_rd != '0;
   end

   always_ff @(posedge clk or posedge clr) begin
      if (clr) begin
         lw_vld  <= 1'b0;
         lw_rd   <= '0;
         dep_d1  <= 1'b0;
         dep_d2  <= 1'b0;
         addr_d1 <= '0;
      end else begin
         lw_vld  <= op == 5'b01000;
         lw_rd   <= f_rd;
         dep_d1  <= dep_now;
         dep_d2  <= dep_d1;
         addr_d1 <= imem_addr;
      end
   end

   reset_state: assert property (@(posedge clk) clr |-> !dmem_wren && imem_addr == RESET_PC)
      else begin $error("Core not in reset state while clr is high"); fails++; end

   after_reset: assert property (@(posedge clk) $fell(clr) |-> !dmem_wren && imem_addr == RESET_PC)
      else begin $error("Core left reset state too early"); fails++; end

   load_use_hold: assert property (@(posedge clk) disable iff (clr) dep_d2 |-> imem_addr == addr_d1)
      else begin $error("Fetch did not hold on a load-use hazard"); fails++; end

   store_range: assert property (@(posedge clk) disable iff (clr)
                                 dmem_wren |-> dmem_addr < word_t'(DATA_WORDS))
      else begin $error("Store outside the data region"); fails++; end

endmodule

/* tb/tb_cpu_core.sv */
// Testbench for the five-stage core
// Instruction and data memory models, test programs
// Sequential ISA reference model and in-order store checking
`timescale 1ns/1ps

module tb_cpu_core import cpu_pkg::*;;

   localparam int MAX_CYCLES = 2000;  // Four short programs, far below this

   logic  clk = 1'b0;
   logic  clr = 1'b0;
   word_t imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
   logic  dmem_wren;
   word_t imem [64];
   word_t dmem [64];
   word_t exp_addr [$];
   word_t exp_data [$];
   int    seen = 0;
   int    errors = 0;
   int    cycles = 0;
   int    n_pass = 0;
   int    n_fail = 0;
   int    seed_val;

   assign imem_data  = imem[imem_addr[5:0]];
   assign dmem_rdata = dmem[dmem_addr[5:0]];

   cpu_core #(.RESET_PC('0)) UUT (.*);

   always #4 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("Some tests failed");
         $finish;
      end
   end

   // Store monitor, compares in program order
   always @(posedge clk) begin
      if (dmem_wren && !clr) begin
         dmem[dmem_addr[5:0]] <= dmem_wdata;
         if (seen < exp_addr.size()) begin
            assert (dmem_addr == exp_addr[seen]) else begin
               $display("Fail dmem_addr: got %h expected %h", dmem_addr, exp_addr[seen]);
               errors++;
            end
            assert (dmem_wdata == exp_data[seen]) else begin
               $display("Fail dmem_wdata: got %h expected %h", dmem_wdata, exp_data[seen]);
               errors++;
            end
         end else begin
            $display("Unexpected store to address %h after all expected stores", dmem_addr);
            errors++;
         end
         seen++;
      end
   end

   function automatic word_t enc_r(logic [4:0] fn, logic [4:0] rd, logic [4:0] rs,
                                   logic [4:0] rt, logic [4:0] sh);
      return {5'b00000, rd, rs, rt, sh, fn, 2'b00};
   endfunction

   function automatic word_t enc_i(logic [4:0] op, logic [4:0] rd, logic [4:0] rs, int imm);
      logic [31:0] v;
      v = imm;
      return {op, rd, rs, v[16:0]};
   endfunction

   function automatic word_t enc_j(int target);
      logic [31:0] v;
      v = target;
      return {5'b00001, v[26:0]};
   endfunction

   // Sequential ISA model, records every store in order
   task automatic run_model(input word_t halt);
      word_t r [32];
      word_t m [64];
      word_t pc, npc, ins, imm, addr, res;
      logic [4:0] op, rd, rs, rt, sh, fn;
      int steps;
      for (int i = 0; i < 32; i++) r[i] = '0;
      for (int i = 0; i < 64; i++) m[i] = dmem[i];
      exp_addr.delete();
      exp_data.delete();
      pc = '0;
      steps = 0;
      while (pc != halt && steps < 200) begin
         ins = imem[pc[5:0]];
         {op, rd, rs, rt, sh, fn} = ins[31:2];
         imm  = {{15{ins[16]}}, ins[16:0]};
         addr = r[rs] + imm;
         npc  = pc + 32'd1;
         case (op)
            5'b00000: begin
               case (fn)
                  5'd0:    res = r[rs] + r[rt];
                  5'd1:    res = r[rs] - r[rt];
                  5'd2:    res = r[rs] & r[rt];
                  5'd3:    res = r[rs] | r[rt];
                  5'd4:    res = r[rs] << sh;
                  5'd5:    res = word_t'($signed(r[rs]) >>> sh);
                  default: res = '0;
               endcase
               r[rd] = res;
            end
            5'b00101: r[rd] = addr;  // addi
            5'b01000: r[rd] = m[addr[5:0]];
            5'b00111: begin
               m[addr[5:0]] = r[rd];
               exp_addr.push_back(addr);
               exp_data.push_back(r[rd]);
            end
            5'b00010: if (r[rd] != r[rs]) npc = pc + 32'd1 + imm;
            5'b00110: if ($signed(r[rd]) < $signed(r[rs])) npc = pc + 32'd1 + imm;
            5'b00001: npc = {{5{ins[26]}}, ins[26:0]};
            default: ;
         endcase
         r[0] = '0;
         pc = npc;
         steps++;
      end
   endtask

   task automatic load_alu(output int halt);
      logic [4:0] sh;
      sh = 5'($urandom_range(31));
      imem[0]  = enc_i(OP_LW, 5'd1, 5'd0, 0);
      imem[1]  = enc_i(OP_LW, 5'd2, 5'd0, 1);
      imem[2]  = enc_i(OP_ADDI, 5'd3, 5'd1, int'($urandom_range(65535)) - 32768);
      imem[3]  = enc_i(OP_SW, 5'd3, 5'd0, 16);
      imem[4]  = enc_r(ALU_ADD, 5'd4, 5'd3, 5'd2, 5'd0);
      imem[5]  = enc_i(OP_SW, 5'd4, 5'd0, 17);
      imem[6]  = enc_r(ALU_SUB, 5'd5, 5'd4, 5'd1, 5'd0);
      imem[7]  = enc_i(OP_SW, 5'd5, 5'd0, 18);
      imem[8]  = enc_r(ALU_AND, 5'd6, 5'd5, 5'd2, 5'd0);
      imem[9]  = enc_i(OP_SW, 5'd6, 5'd0, 19);
      imem[10] = enc_r(ALU_OR, 5'd7, 5'd6, 5'd1, 5'd0);
      imem[11] = enc_i(OP_SW, 5'd7, 5'd0, 20);
      imem[12] = enc_r(ALU_SLL, 5'd8, 5'd7, 5'd0, sh);
      imem[13] = enc_i(OP_SW, 5'd8, 5'd0, 21);
      imem[14] = enc_r(ALU_SRA, 5'd9, 5'd1, 5'd0, sh);
      imem[15] = enc_i(OP_SW, 5'd9, 5'd0, 22);
      halt = 16;
   endtask

   task automatic load_use(output int halt);
      imem[0] = enc_i(OP_LW, 5'd1, 5'd0, 2);
      imem[1] = enc_i(OP_LW, 5'd2, 5'd0, 3);
      imem[2] = enc_r(ALU_ADD, 5'd3, 5'd2, 5'd1, 5'd0);  // Uses r2 right after its load
      imem[3] = enc_i(OP_SW, 5'd3, 5'd0, 24);
      halt = 4;
   endtask

   task automatic load_branch(output int halt);
      imem[0]  = enc_i(OP_LW, 5'd1, 5'd0, 4);
      imem[1]  = enc_i(OP_LW, 5'd2, 5'd0, 5);
      imem[2]  = enc_i(OP_ADDI, 5'd3, 5'd0, 5);
      imem[3]  = enc_i(OP_ADDI, 5'd4, 5'd0, -3);
      imem[4]  = enc_i(OP_BNE, 5'd3, 5'd3, 2);  // Not taken
      imem[5]  = enc_i(OP_SW, 5'd3, 5'd0, 32);
      imem[6]  = enc_i(OP_SW, 5'd4, 5'd0, 33);
      imem[7]  = enc_i(OP_BNE, 5'd3, 5'd4, 2);  // Taken
      imem[8]  = enc_i(OP_SW, 5'd3, 5'd0, 34);
      imem[9]  = enc_i(OP_SW, 5'd4, 5'd0, 35);
      imem[10] = enc_i(OP_BLT, 5'd4, 5'd3, 2);  // -3 < 5, taken
      imem[11] = enc_i(OP_SW, 5'd3, 5'd0, 36);
      imem[12] = enc_i(OP_SW, 5'd4, 5'd0, 37);
      imem[13] = enc_i(OP_BLT, 5'd3, 5'd4, 2);
      imem[14] = enc_i(OP_SW, 5'd3, 5'd0, 38);
      imem[15] = enc_i(OP_BLT, 5'd1, 5'd2, 2);  // Random outcome
      imem[16] = enc_i(OP_SW, 5'd1, 5'd0, 39);
      imem[17] = enc_i(OP_SW, 5'd2, 5'd0, 40);
      halt = 18;
   endtask

   task automatic load_jump(output int halt);
      imem[0] = enc_i(OP_ADDI, 5'd1, 5'd0, 7);
      imem[1] = enc_j(4);
      imem[2] = enc_i(OP_SW, 5'd1, 5'd0, 48);
      imem[3] = enc_i(OP_SW, 5'd1, 5'd0, 49);
      imem[4] = enc_i(OP_SW, 5'd1, 5'd0, 50);
      halt = 5;
   endtask

   task automatic run_test(input int num, input string name);
      int halt;
      int err0;
      int afail0;
      @(posedge clk);
      #1 clr = 1'b1;  // Hold the core while memories reload
      for (int i = 0; i < 64; i++) dmem[i] = $urandom;
      case (num)
         1:       load_alu(halt);
         2:       load_use(halt);
         3:       load_branch(halt);
         default: load_jump(halt);
      endcase
      for (int i = halt; i < 64; i++) imem[i] = enc_j(halt);  // Halt loop
      run_model(word_t'(halt));
      seen   = 0;
      err0   = errors;
      afail0 = UUT.u_assert.fails;
      repeat (8) @(posedge clk);
      #1 clr = 1'b0;
      while (imem_addr != word_t'(halt)) @(posedge clk);
      repeat (6) @(posedge clk);  // Drain the pipeline
      if (seen < exp_addr.size()) begin
         $display("Missing stores: saw %0d of %0d", seen, exp_addr.size());
         errors++;
      end
      if (errors == err0 && UUT.u_assert.fails == afail0) begin
         $display("Test %0d %s: pass", num, name);
         n_pass++;
      end else begin
         $display("Test %0d %s: FAIL", num, name);
         n_fail++;
      end
   endtask

   initial begin
      seed_val = $urandom(48132);
      #1 clr = 1'b1;  // Rising edge resets the core before the first clock
      for (int i = 0; i < 64; i++) imem[i] = enc_j(0);
      for (int i = 0; i < 64; i++) dmem[i] = '0;
      run_test(1, "alu_forwarding");
      run_test(2, "load_use");
      run_test(3, "branches");
      run_test(4, "jump");
      $display("Tests passed %0d, failed %0d, check errors %0d, assertion failures %0d",
               n_pass, n_fail, errors, UUT.u_assert.fails);
      if (n_fail == 0 && errors == 0 && UUT.u_assert.fails == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

bind cpu_core cpu_core_assert #(.RESET_PC(RESET_PC), .DATA_WORDS(64)) u_assert (.*);

/* verilog.f */
hdl/cpu_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/hazard_unit.sv
hdl/execute_stage.sv
hdl/mem_wb_stage.sv
hdl/cpu_core.sv
tb/cpu_core_assert.sv
tb/tb_cpu_core.sv

/* Makefile */
TOP = tb_cpu_core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check sim.log for the pass message"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -o sim
	./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log
